// ==== source/frogger_params.svh ====
// traffic tick periods are sized for short simulations, not for a visible game speed
`ifndef FROGGER_PARAMS_SVH
`define FROGGER_PARAMS_SVH

// grid
`define FROG_COLS   16
`define FROG_ROWS   7
`define FROG_LANES  4

// pixel pitch of one cell, tile size and frame buffer stride
`define CELL_W      10
`define CELL_H      15
`define TILE_SIDE   8
`define SCREEN_W    160

`define START_COL   4'd8
`define START_ROW   3'd6

// bit (15 - column) set means a car in that cell
`define LANE0_INIT  16'b1000_1101_1000_0000
`define LANE1_INIT  16'b1100_0011_0001_0011
`define LANE2_INIT  16'b0011_0111_0001_1001
`define LANE3_INIT  16'b0110_0011_1001_1100

// traffic tick periods in fastclock cycles
`define TICK_W      16
`define TICK_SPEED1 16'd2000
`define TICK_SPEED2 16'd1000
`define TICK_SPEED3 16'd500

`define COLOUR_FROG 3'b111
`define COLOUR_CAR  3'b110
`define COLOUR_ROAD 3'b000

`endif

// ==== source/frogger_pkg.sv ====
// lane index 0 is grid row 1; bit 15 of a lane row is grid column 0
`default_nettype none
`include "frogger_params.svh"

package frogger_pkg;

    typedef logic [2:0]  colour_t;
    typedef logic [3:0]  col_t;
    typedef logic [2:0]  row_t;
    typedef logic [14:0] pix_adr_t;
    typedef logic [`FROG_LANES-1:0][`FROG_COLS-1:0] lane_rows_t;

    typedef enum logic [1:0] {
        speed_frozen,
        speed_slow,
        speed_mid,
        speed_fast
    } speed_t;

    typedef enum logic [1:0] {
        game_play,
        game_won,
        game_lost
    } game_state_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_sweep,
        seq_erase,
        seq_draw
    } seq_state_t;

    typedef enum logic [1:0] {
        paint_idle,
        paint_write,
        paint_done
    } paint_state_t;

endpackage

`default_nettype wire

// ==== source/traffic_lanes.sv ====
// a speed change takes effect at the next counter reload; leaving frozen ticks at once
`timescale 1ns/1ps
`default_nettype none
`include "frogger_params.svh"

module traffic_lanes (
    input  wire                      fastclock,
    input  wire                      resetn,
    input  wire frogger_pkg::speed_t speed,
    output frogger_pkg::lane_rows_t  lanes
);

    logic [`TICK_W-1:0] tick_cnt;
    logic [`TICK_W-1:0] reload;
    logic               tick;

    always_comb begin
        case (speed)
            frogger_pkg::speed_slow: reload = `TICK_SPEED1 - 1'b1;
            frogger_pkg::speed_mid:  reload = `TICK_SPEED2 - 1'b1;
            frogger_pkg::speed_fast: reload = `TICK_SPEED3 - 1'b1;
            default:                 reload = '0;
        endcase
    end

    // no ticks while frozen
    assign tick = (speed != frogger_pkg::speed_frozen) && (tick_cnt == '0);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (tick_cnt == '0) begin
            tick_cnt <= reload;
        end else begin
            tick_cnt <= tick_cnt - 1'b1;
        end
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            lanes[0] <= `LANE0_INIT;
            lanes[1] <= `LANE1_INIT;
            lanes[2] <= `LANE2_INIT;
            lanes[3] <= `LANE3_INIT;
        end else if (tick) begin
            // rotate left, top bit wraps into bit 0
            for (int i = 0; i < `FROG_LANES; i++) begin
                lanes[i] <= {lanes[i][`FROG_COLS-2:0], lanes[i][`FROG_COLS-1]};
            end
        end
    end

    a_frozen_lanes_hold: assert property (
        @(posedge fastclock) disable iff (!resetn)
        speed == frogger_pkg::speed_frozen |=> $stable(lanes)
    );

endmodule

`default_nettype wire

// ==== source/frog_tracker.sv ====
// one move per key press, first legal key wins in order up, down, left, right
`timescale 1ns/1ps
`default_nettype none
`include "frogger_params.svh"

module frog_tracker (
    input  wire                          fastclock,
    input  wire                          resetn,
    input  wire                          key_up,
    input  wire                          key_down,
    input  wire                          key_left,
    input  wire                          key_right,
    input  wire                          move_enable,
    input  wire                          respawn,
    input  wire                          redraw_ack,
    input  wire frogger_pkg::lane_rows_t lanes,
    output frogger_pkg::col_t            frog_col,
    output frogger_pkg::row_t            frog_row,
    output frogger_pkg::col_t            old_col,
    output frogger_pkg::row_t            old_row,
    output logic                         redraw_req,
    output logic                         collide,
    output logic                         goal
);

    logic [3:0]        keys_q;
    logic [3:0]        key_rise;
    frogger_pkg::col_t next_col;
    frogger_pkg::row_t next_row;
    logic              moved;
    logic [1:0]        lane_idx;
    logic [3:0]        bit_idx;

    // up, down, left, right
    assign key_rise = {key_up, key_down, key_left, key_right} & ~keys_q;

    always_comb begin
        next_col = frog_col;
        next_row = frog_row;
        if (key_rise[3] && frog_row != 3'd0) begin
            next_row = frog_row - 3'd1;
        end else if (key_rise[2] && frog_row != 3'(`FROG_ROWS - 1)) begin
            next_row = frog_row + 3'd1;
        end else if (key_rise[1] && frog_col != 4'd0) begin
            next_col = frog_col - 4'd1;
        end else if (key_rise[0] && frog_col != 4'(`FROG_COLS - 1)) begin
            next_col = frog_col + 4'd1;
        end
    end

    // presses during a pending redraw are dropped
    assign moved = move_enable && !redraw_req &&
                   (next_col != frog_col || next_row != frog_row);

    assign lane_idx = 2'(frog_row - 3'd1);
    assign bit_idx  = 4'(`FROG_COLS - 1) - frog_col;
    assign collide  = (frog_row >= 3'd1) && (frog_row <= 3'(`FROG_LANES)) &&
                      lanes[lane_idx][bit_idx];
    assign goal     = (frog_row == 3'd0);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            keys_q     <= '0;
            frog_col   <= `START_COL;
            frog_row   <= `START_ROW;
            old_col    <= `START_COL;
            old_row    <= `START_ROW;
            redraw_req <= 1'b0;
        end else begin
            keys_q <= {key_up, key_down, key_left, key_right};
            if (respawn) begin
                old_col    <= frog_col;
                old_row    <= frog_row;
                frog_col   <= `START_COL;
                frog_row   <= `START_ROW;
                redraw_req <= 1'b1;
            end else if (moved) begin
                old_col    <= frog_col;
                old_row    <= frog_row;
                frog_col   <= next_col;
                frog_row   <= next_row;
                redraw_req <= 1'b1;
            end else if (redraw_ack) begin
                redraw_req <= 1'b0;
            end
        end
    end

    a_frog_row_on_grid: assert property (
        @(posedge fastclock) disable iff (!resetn)
        frog_row < 3'(`FROG_ROWS)
    );

endmodule

`default_nettype wire

// ==== source/game_control.sv ====
// restart counts only on its rising edge and only in an end state
`timescale 1ns/1ps
`default_nettype none

module game_control (
    input  wire                      fastclock,
    input  wire                      resetn,
    input  wire                      key_restart,
    input  wire                      collide,
    input  wire                      goal,
    output frogger_pkg::game_state_t game_state,
    output logic                     move_enable,
    output logic                     respawn
);

    logic restart_q;
    logic restart_rise;

    assign restart_rise = key_restart && !restart_q;
    assign move_enable  = (game_state == frogger_pkg::game_play);

    // frog leaves the end cell on the same edge that play resumes
    assign respawn = !move_enable && restart_rise;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            restart_q  <= 1'b0;
            game_state <= frogger_pkg::game_play;
        end else begin
            restart_q <= key_restart;
            case (game_state)
                frogger_pkg::game_play: begin
                    if (collide) begin
                        game_state <= frogger_pkg::game_lost;
                    end else if (goal) begin
                        game_state <= frogger_pkg::game_won;
                    end
                end
                default: begin
                    if (restart_rise) begin
                        game_state <= frogger_pkg::game_play;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/tile_painter.sv ====
// tile position and colour must hold from tile_req until tile_done
`timescale 1ns/1ps
`default_nettype none
`include "frogger_params.svh"

module tile_painter (
    input  wire                       fastclock,
    input  wire                       resetn,
    input  wire                       tile_req,
    input  wire frogger_pkg::col_t    tile_col,
    input  wire frogger_pkg::row_t    tile_row,
    input  wire frogger_pkg::colour_t tile_colour,
    input  wire                       wb_ack,
    output logic                      tile_done,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output frogger_pkg::pix_adr_t     wb_adr,
    output frogger_pkg::colour_t      wb_dat
);

    frogger_pkg::paint_state_t state;
    logic [5:0] pix_cnt;
    logic [7:0] org_x;
    logic [6:0] org_y;
    logic       last_pix;

    // tile origin on screen
    assign org_x    = 8'(tile_col * `CELL_W);
    assign org_y    = 7'(tile_row * `CELL_H);
    assign last_pix = (pix_cnt == 6'(`TILE_SIDE * `TILE_SIDE - 1));

    assign wb_cyc    = (state == frogger_pkg::paint_write);
    assign wb_stb    = wb_cyc;
    assign wb_we     = wb_cyc;
    assign wb_dat    = tile_colour;
    assign wb_adr    = 15'((org_y + pix_cnt / `TILE_SIDE) * `SCREEN_W +
                           org_x + pix_cnt % `TILE_SIDE);
    assign tile_done = (state == frogger_pkg::paint_done);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state   <= frogger_pkg::paint_idle;
            pix_cnt <= '0;
        end else begin
            case (state)
                frogger_pkg::paint_idle: begin
                    if (tile_req) begin
                        state   <= frogger_pkg::paint_write;
                        pix_cnt <= '0;
                    end
                end
                frogger_pkg::paint_write: begin
                    // a slow slave just stretches the write
                    if (wb_ack) begin
                        if (last_pix) begin
                            state <= frogger_pkg::paint_done;
                        end else begin
                            pix_cnt <= pix_cnt + 6'd1;
                        end
                    end
                end
                default: state <= frogger_pkg::paint_idle;
            endcase
        end
    end

    a_write_held_until_ack: assert property (
        @(posedge fastclock) disable iff (!resetn)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat)
    );

endmodule

`default_nettype wire

// ==== source/scene_sequencer.sv ====
// frog tile is drawn once after reset; rows 0, 5 and 6 change only through redraws
`timescale 1ns/1ps
`default_nettype none
`include "frogger_params.svh"

module scene_sequencer (
    input  wire                          fastclock,
    input  wire                          resetn,
    input  wire frogger_pkg::lane_rows_t lanes,
    input  wire frogger_pkg::col_t       frog_col,
    input  wire frogger_pkg::row_t       frog_row,
    input  wire frogger_pkg::col_t       old_col,
    input  wire frogger_pkg::row_t       old_row,
    input  wire                          redraw_req,
    input  wire                          tile_done,
    output logic                         redraw_ack,
    output logic                         tile_req,
    output frogger_pkg::col_t            tile_col,
    output frogger_pkg::row_t            tile_row,
    output frogger_pkg::colour_t         tile_colour
);

    frogger_pkg::seq_state_t state;
    frogger_pkg::col_t       sweep_col;
    logic [1:0]              sweep_lane;
    frogger_pkg::row_t       sweep_row;
    frogger_pkg::colour_t    sweep_colour;
    logic                    pick;
    logic                    load_draw;
    logic                    load_erase;
    logic                    load_sweep;

    assign sweep_row = {1'b0, sweep_lane} + 3'd1;

    always_comb begin
        if (frog_col == sweep_col && frog_row == sweep_row) begin
            sweep_colour = `COLOUR_FROG;
        end else if (lanes[sweep_lane][4'(`FROG_COLS - 1) - sweep_col]) begin
            sweep_colour = `COLOUR_CAR;
        end else begin
            sweep_colour = `COLOUR_ROAD;
        end
    end

    // next tile is chosen only when the current one is finished
    assign pick       = tile_done && (state != frogger_pkg::seq_erase);
    assign load_draw  = (state == frogger_pkg::seq_idle) ||
                        (tile_done && state == frogger_pkg::seq_erase);
    assign load_erase = pick && redraw_req;
    assign load_sweep = pick && !redraw_req;

    // ack on the same edge that latches the old cell
    assign redraw_ack = load_erase;

    assign tile_req = (state != frogger_pkg::seq_idle);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state      <= frogger_pkg::seq_idle;
            sweep_col  <= '0;
            sweep_lane <= '0;
        end else begin
            if (load_draw) begin
                state <= frogger_pkg::seq_draw;
            end else if (load_erase) begin
                state <= frogger_pkg::seq_erase;
            end else if (load_sweep) begin
                state     <= frogger_pkg::seq_sweep;
                sweep_col <= sweep_col + 4'd1;
                if (sweep_col == 4'(`FROG_COLS - 1)) begin
                    sweep_lane <= sweep_lane + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge fastclock) begin
        if (load_draw) begin
            tile_col    <= frog_col;
            tile_row    <= frog_row;
            tile_colour <= `COLOUR_FROG;
        end else if (load_erase) begin
            tile_col    <= old_col;
            tile_row    <= old_row;
            tile_colour <= `COLOUR_ROAD;
        end else if (load_sweep) begin
            tile_col    <= sweep_col;
            tile_row    <= sweep_row;
            tile_colour <= sweep_colour;
        end
    end

endmodule

`default_nettype wire

// ==== source/frogger_top.sv ====
// the frame buffer must be a Wishbone classic slave; keys are active-high synchronous levels
`timescale 1ns/1ps
`default_nettype none

module frogger_top (
    input  wire                           fastclock,
    input  wire                           resetn,
    input  wire                           key_up,
    input  wire                           key_down,
    input  wire                           key_left,
    input  wire                           key_right,
    input  wire                           key_restart,
    input  wire frogger_pkg::speed_t      speed,
    output wire frogger_pkg::game_state_t game_state,
    output wire                           wb_cyc,
    output wire                           wb_stb,
    output wire                           wb_we,
    output wire frogger_pkg::pix_adr_t    wb_adr,
    output wire frogger_pkg::colour_t     wb_dat,
    input  wire                           wb_ack
);

    wire frogger_pkg::lane_rows_t lanes;
    wire frogger_pkg::col_t       frog_col;
    wire frogger_pkg::row_t       frog_row;
    wire frogger_pkg::col_t       old_col;
    wire frogger_pkg::row_t       old_row;
    wire frogger_pkg::col_t       tile_col;
    wire frogger_pkg::row_t       tile_row;
    wire frogger_pkg::colour_t    tile_colour;
    wire redraw_req;
    wire redraw_ack;
    wire collide;
    wire goal;
    wire move_enable;
    wire respawn;
    wire tile_req;
    wire tile_done;

    traffic_lanes u_traffic (
        .fastclock(fastclock),
        .resetn(resetn),
        .speed(speed),
        .lanes(lanes)
    );

    frog_tracker u_frog (
        .fastclock(fastclock),
        .resetn(resetn),
        .key_up(key_up),
        .key_down(key_down),
        .key_left(key_left),
        .key_right(key_right),
        .move_enable(move_enable),
        .respawn(respawn),
        .redraw_ack(redraw_ack),
        .lanes(lanes),
        .frog_col(frog_col),
        .frog_row(frog_row),
        .old_col(old_col),
        .old_row(old_row),
        .redraw_req(redraw_req),
        .collide(collide),
        .goal(goal)
    );

    game_control u_game (
        .fastclock(fastclock),
        .resetn(resetn),
        .key_restart(key_restart),
        .collide(collide),
        .goal(goal),
        .game_state(game_state),
        .move_enable(move_enable),
        .respawn(respawn)
    );

    scene_sequencer u_seq (
        .fastclock(fastclock),
        .resetn(resetn),
        .lanes(lanes),
        .frog_col(frog_col),
        .frog_row(frog_row),
        .old_col(old_col),
        .old_row(old_row),
        .redraw_req(redraw_req),
        .tile_done(tile_done),
        .redraw_ack(redraw_ack),
        .tile_req(tile_req),
        .tile_col(tile_col),
        .tile_row(tile_row),
        .tile_colour(tile_colour)
    );

    tile_painter u_painter (
        .fastclock(fastclock),
        .resetn(resetn),
        .tile_req(tile_req),
        .tile_col(tile_col),
        .tile_row(tile_row),
        .tile_colour(tile_colour),
        .wb_ack(wb_ack),
        .tile_done(tile_done),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat(wb_dat)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// free-running clock from time zero, first rising edge after half a period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic fastclock
);

    initial begin
        fastclock = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) fastclock = ~fastclock;
        end
    end

endmodule

`default_nettype wire

// ==== dv/frogger_tb.sv ====
// exact lane checks need frozen traffic; the slave acks each write after 1 to 4 cycles
`timescale 1ns/1ps
`default_nettype none
`include "frogger_params.svh"

module frogger_tb;

    localparam int ACT_WAIT    = 0;
    localparam int ACT_UP      = 1;
    localparam int ACT_DOWN    = 2;
    localparam int ACT_LEFT    = 3;
    localparam int ACT_RIGHT   = 4;
    localparam int ACT_RESTART = 5;
    localparam int ACT_SPEED   = 6;

    // lane check after a step is none, the reset patterns or any common rotation
    localparam int LANES_SKIP  = 0;
    localparam int LANES_RESET = 1;
    localparam int LANES_ROT   = 2;

    logic                     fastclock;
    logic                     resetn;
    logic                     key_up;
    logic                     key_down;
    logic                     key_left;
    logic                     key_right;
    logic                     key_restart;
    frogger_pkg::speed_t      speed;
    frogger_pkg::game_state_t game_state;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    frogger_pkg::pix_adr_t    wb_adr;
    frogger_pkg::colour_t     wb_dat;
    logic                     wb_ack = 1'b0;

    frogger_pkg::colour_t     frame [0:32767];
    logic [7:0]               lfsr = 8'd84;
    int                       ack_wait = 0;
    int                       limit_cycles = 0;
    int                       state_errors = 0;
    int                       pixel_errors = 0;
    int                       other_errors = 0;

    int                       step_act[$];
    int                       step_arg[$];
    int                       step_kcyc[$];
    frogger_pkg::game_state_t step_state[$];
    int                       step_col[$];
    int                       step_row[$];
    int                       step_lanes[$];

    tb_clock_gen #(.PERIOD_NS(10.0)) u_clk (.fastclock(fastclock));

    frogger_top uut (
        .fastclock(fastclock),
        .resetn(resetn),
        .key_up(key_up),
        .key_down(key_down),
        .key_left(key_left),
        .key_right(key_right),
        .key_restart(key_restart),
        .speed(speed),
        .game_state(game_state),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat(wb_dat),
        .wb_ack(wb_ack)
    );

    // taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    task automatic draw_delay(output int d);
        logic [1:0] bits;
        bits[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        bits[1] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d = 1 + int'(bits);
    endtask

    // frame buffer slave
    always @(negedge fastclock) begin
        if (!resetn) begin
            // unwritten pixels read 1 or 3 and match no game colour
            for (int a = 0; a < 32768; a++) begin
                frame[a] = {1'b0, ^a[14:0], 1'b1};
            end
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb && wb_we) begin
            if (ack_wait == 0) begin
                draw_delay(ack_wait);
            end
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                frame[wb_adr] = wb_dat;
                wb_ack = 1'b1;
            end else begin
                wb_ack = 1'b0;
            end
        end else begin
            wb_ack = 1'b0;
        end
    end

    function automatic frogger_pkg::pix_adr_t tile_adr(input int col, input int row, input int k);
        return frogger_pkg::pix_adr_t'((row * `CELL_H + k / `TILE_SIDE) * `SCREEN_W
                                       + col * `CELL_W + k % `TILE_SIDE);
    endfunction

    function automatic logic [15:0] lane_init(input int i);
        case (i)
            0: return `LANE0_INIT;
            1: return `LANE1_INIT;
            2: return `LANE2_INIT;
            default: return `LANE3_INIT;
        endcase
    endfunction

    function automatic logic [15:0] rotl16(input logic [15:0] p, input int r);
        return 16'({p, p} >> (16 - r));
    endfunction

    task automatic check_state(input frogger_pkg::game_state_t got,
                               input frogger_pkg::game_state_t exp);
        if (got !== exp) begin
            state_errors++;
            $display("** Error @ %0t: game_state = %s, expected %s",
                     $time, got.name(), exp.name());
        end
    endtask

    task automatic check_pixel(input frogger_pkg::pix_adr_t adr,
                               input frogger_pkg::colour_t exp);
        if (frame[adr] !== exp) begin
            pixel_errors++;
            $display("** Error @ %0t: frame[%0d] = %0d, expected %0d",
                     $time, adr, frame[adr], exp);
        end
    endtask

    task automatic check_tile(input int col, input int row, input frogger_pkg::colour_t colour);
        for (int k = 0; k < `TILE_SIDE * `TILE_SIDE; k++) begin
            check_pixel(tile_adr(col, row, k), colour);
        end
    endtask

    task automatic check_lanes_as(input int r);
        logic [15:0] pat;
        for (int i = 0; i < `FROG_LANES; i++) begin
            pat = rotl16(lane_init(i), r);
            for (int c = 0; c < `FROG_COLS; c++) begin
                check_tile(c, i + 1, pat[15 - c] ? `COLOUR_CAR : `COLOUR_ROAD);
            end
        end
    endtask

    // -1 when no single rotation explains all four lanes
    task automatic find_rotation(output int rot);
        logic [15:0] obs [4];
        logic        match;
        rot = -1;
        for (int i = 0; i < `FROG_LANES; i++) begin
            for (int c = 0; c < `FROG_COLS; c++) begin
                obs[i][15 - c] = (frame[tile_adr(c, i + 1, 0)] == `COLOUR_CAR);
            end
        end
        for (int r = `FROG_COLS - 1; r >= 0; r--) begin
            match = 1'b1;
            for (int i = 0; i < `FROG_LANES; i++) begin
                if (obs[i] != rotl16(lane_init(i), r)) begin
                    match = 1'b0;
                end
            end
            if (match) begin
                rot = r;
            end
        end
    endtask

    task automatic add_step(input int act, input int arg, input int kcyc,
                            input frogger_pkg::game_state_t st, input int col,
                            input int row, input int lanes_mode);
        step_act.push_back(act);
        step_arg.push_back(arg);
        step_kcyc.push_back(kcyc);
        step_state.push_back(st);
        step_col.push_back(col);
        step_row.push_back(row);
        step_lanes.push_back(lanes_mode);
    endtask

    task automatic build_scenario();
        add_step(ACT_WAIT,    0, 20, frogger_pkg::game_play, 8, 6, LANES_RESET);
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_play, 8, 5, LANES_SKIP);
        for (int c = 7; c >= 0; c--) begin
            add_step(ACT_LEFT, 0, 1, frogger_pkg::game_play, c, 5, LANES_SKIP);
        end
        // already at the left edge
        add_step(ACT_LEFT,    0, 1,  frogger_pkg::game_play, 0, 5, LANES_SKIP);
        add_step(ACT_DOWN,    0, 1,  frogger_pkg::game_play, 0, 6, LANES_SKIP);
        // already on the bottom row
        add_step(ACT_DOWN,    0, 1,  frogger_pkg::game_play, 0, 6, LANES_SKIP);
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_play, 0, 5, LANES_SKIP);
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_play, 0, 4, LANES_SKIP);
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_play, 0, 3, LANES_SKIP);
        // lane 1 has a car at column 0
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_lost, 0, 2, LANES_SKIP);
        add_step(ACT_RIGHT,   0, 1,  frogger_pkg::game_lost, 0, 2, LANES_SKIP);
        add_step(ACT_RESTART, 0, 1,  frogger_pkg::game_play, 8, 6, LANES_SKIP);
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_play, 8, 5, LANES_SKIP);
        add_step(ACT_RIGHT,   0, 1,  frogger_pkg::game_play, 9, 5, LANES_SKIP);
        // column 9 is free in all four lanes
        for (int r = 4; r >= 1; r--) begin
            add_step(ACT_UP,   0, 1, frogger_pkg::game_play, 9, r, LANES_SKIP);
        end
        add_step(ACT_UP,      0, 1,  frogger_pkg::game_won,  9, 0, LANES_SKIP);
        add_step(ACT_RESTART, 0, 1,  frogger_pkg::game_play, 8, 6, LANES_SKIP);
        add_step(ACT_SPEED,   3, 5,  frogger_pkg::game_play, 8, 6, LANES_SKIP);
        add_step(ACT_SPEED,   0, 40, frogger_pkg::game_play, 8, 6, LANES_ROT);
    endtask

    task automatic apply_action(input int act, input int arg);
        case (act)
            ACT_UP:      key_up = 1'b1;
            ACT_DOWN:    key_down = 1'b1;
            ACT_LEFT:    key_left = 1'b1;
            ACT_RIGHT:   key_right = 1'b1;
            ACT_RESTART: key_restart = 1'b1;
            ACT_SPEED:   speed = frogger_pkg::speed_t'(arg);
            default:     ;
        endcase
        @(negedge fastclock);
        key_up      = 1'b0;
        key_down    = 1'b0;
        key_left    = 1'b0;
        key_right   = 1'b0;
        key_restart = 1'b0;
    endtask

    initial begin
        int   prev_col;
        int   prev_row;
        int   rot;
        int   total;
        logic moved;
        resetn      = 1'b0;
        key_up      = 1'b0;
        key_down    = 1'b0;
        key_left    = 1'b0;
        key_right   = 1'b0;
        key_restart = 1'b0;
        speed       = frogger_pkg::speed_frozen;
        build_scenario();
        total = 0;
        foreach (step_kcyc[i]) begin
            total += step_kcyc[i] * 1000 + 2;
        end
        limit_cycles = total + 10 + 5000;

        repeat (10) @(posedge fastclock);
        @(negedge fastclock);
        resetn   = 1'b1;
        prev_col = 8;
        prev_row = 6;

        foreach (step_act[i]) begin
            @(negedge fastclock);
            apply_action(step_act[i], step_arg[i]);
            repeat (step_kcyc[i] * 1000) @(negedge fastclock);
            // frame and outputs are settled between edges
            #1;
            check_state(game_state, step_state[i]);
            check_tile(step_col[i], step_row[i], `COLOUR_FROG);
            moved = (step_col[i] != prev_col) || (step_row[i] != prev_row);
            if (moved && (prev_row == 0 || prev_row > `FROG_LANES)) begin
                check_tile(prev_col, prev_row, `COLOUR_ROAD);
            end
            if (step_lanes[i] == LANES_RESET) begin
                check_lanes_as(0);
            end else if (step_lanes[i] == LANES_ROT) begin
                find_rotation(rot);
                if (rot < 0) begin
                    other_errors++;
                    $display("step %0d: lane tiles are not one common rotation of the start",
                             i);
                end else begin
                    check_lanes_as(rot);
                end
            end
            prev_col = step_col[i];
            prev_row = step_row[i];
        end

        $display("errors: state %0d, pixel %0d, other %0d",
                 state_errors, pixel_errors, other_errors);
        if (state_errors + pixel_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge fastclock);
        $display("timeout: stimulus table not finished after %0d cycles", limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/frogger_pkg.sv
source/traffic_lanes.sv
source/frog_tracker.sv
source/game_control.sv
source/tile_painter.sv
source/scene_sequencer.sv
source/frogger_top.sv
dv/tb_clock_gen.sv
dv/frogger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module frogger_tb \
    -o frogger_sim \
    && ./obj_dir/frogger_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
